/* dv/ibuf_trace.txt */
# name init resteer br_fix line_e line_o fip_e fip_o miss_e miss_o stall_e stall_o nbip obip
# expected: valid[3:0] even_loaded odd_loaded tag0 tag1 tag2 tag3 (lines, tags, bips in hex)
reset_state           0 0 0 11 12 0 1 0 0 0 0 00 00 0000 1 1 00 00 00 00
load_both_fill        0 0 0 21 22 2 3 0 0 0 0 00 00 0011 1 1 11 12 00 00
load_both_fill        0 0 0 31 32 0 1 0 0 0 0 00 00 1111 1 1 11 12 21 22
load_both_fill        0 0 0 41 42 2 3 0 0 0 0 00 00 1111 0 0 31 32 21 22
bip_wrap_invalidate   0 0 0 51 52 0 1 0 0 0 0 12 0e 1111 0 0 31 32 21 22
bip_wrap_invalidate   0 0 0 61 62 0 1 0 0 0 0 12 12 1110 0 0 31 32 21 22
bip_wrap_invalidate   0 0 0 71 72 0 1 0 0 0 0 20 1f 1110 1 0 31 32 21 22
bip_wrap_invalidate   0 0 0 81 82 2 1 0 0 0 0 20 20 1101 1 0 71 32 21 22
miss_and_stall        0 0 0 91 92 0 1 1 0 0 0 01 0f 1101 0 1 71 32 81 22
miss_and_stall        0 0 0 a1 a2 0 3 0 1 0 0 00 00 1110 0 0 71 92 81 22
miss_and_stall        0 0 0 b1 b2 0 3 0 0 0 0 00 00 1110 0 1 71 92 81 22
miss_and_stall        0 0 0 c1 c2 0 1 0 0 1 0 13 1a 1110 0 0 71 92 81 b2
miss_and_stall        0 0 0 d1 d2 0 1 0 0 0 0 00 00 1100 1 0 71 92 81 b2
miss_and_stall        0 0 0 e1 e2 2 1 0 0 0 1 00 00 1101 1 0 d1 92 81 b2
miss_and_stall        0 0 0 f1 f2 0 1 1 0 0 0 00 00 1101 0 1 d1 92 e1 b2
control_flow_flush    1 0 0 10 20 0 3 0 0 0 0 00 00 1111 1 1 d1 f2 e1 b2
control_flow_flush    0 1 0 30 40 2 1 0 0 0 0 00 00 1001 1 1 10 f2 e1 20
control_flow_flush    0 0 1 50 60 0 3 0 0 1 0 00 00 0110 0 1 10 40 30 20
load_beats_invalidate 0 0 0 70 80 0 1 0 0 0 0 02 08 1000 1 1 10 40 30 60
load_beats_invalidate 0 0 0 90 a0 2 3 0 0 0 0 30 35 1011 1 1 70 80 30 60
load_beats_invalidate 0 0 0 b0 c0 0 1 1 1 0 0 00 00 1111 0 0 70 80 90 a0

/* src.f */
logic/ibuf_geom_pkg.sv
logic/ibuf_mode_pkg.sv
logic/ibuf_load_state.sv
logic/ibuf_invalidate.sv
logic/ibuf_load_select.sv
logic/ibuf_line_store.sv
logic/ibuf_latch.sv
dv/ibuf_checker.sv
dv/ibuf_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the instruction buffer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log \
    && verilator --binary --timing --assert -f src.f --top-module ibuf_tb -o ibuf_sim \
        > build.log 2>&1 \
    && ./obj_dir/ibuf_sim > sim.log 2>&1 \
    && grep -qx "TB PASSED" sim.log \
    && echo "ibuf simulation passed" \
    || { echo "ibuf simulation failed, see build.log and sim.log"; exit 1; }

/* dv/ibuf_tb.sv */
module ibuf_tb;
    import ibuf_geom_pkg::*;

    localparam int LINE_W      = DEF_LINE_W;
    localparam int NAME_LEN    = 24;
    localparam int CLK_HALF    = 4;
    localparam int DRIVE_DLY   = 1;
    localparam int RST_CYCLES  = 5;
    localparam int RST_LIMIT   = 10;
    localparam int CYCLE_LIMIT = 200;
    localparam int SKIP_LIMIT  = 50;   // comment lines in a row
    localparam logic [8*NAME_LEN-1:0] COMMENT_TOK = {{(NAME_LEN-1){8'h00}}, 8'h23};

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             is_init, is_resteer, is_br_fix;
    logic [7:0]                       tag_even, tag_odd;
    logic [LINE_W-1:0]                line_even, line_odd;
    slot_idx_t                        fip_e_lsb, fip_o_lsb;
    logic                             miss_even, miss_odd, stall_even, stall_odd;
    logic [BIP_W-1:0]                 new_bip, old_bip;
    logic [NUM_SLOTS-1:0][LINE_W-1:0] slot_data;
    logic [NUM_SLOTS-1:0]             slot_valid;
    logic                             even_loaded, odd_loaded;
    logic                             check_en;
    logic [8*NAME_LEN-1:0]            test_name;
    logic [NUM_SLOTS-1:0]             exp_valid;
    logic                             exp_even_loaded, exp_odd_loaded;
    logic [7:0]                       exp_tag0, exp_tag1, exp_tag2, exp_tag3;
    logic [8*160-1:0]                 skip_buf;
    int                               fd, other_errs, check_errs, checks, cycles, wait_cycles;
    bit                               got, done;

    assign line_even = {(LINE_W/8){tag_even}};
    assign line_odd  = {(LINE_W/8){tag_odd}};

    always #(CLK_HALF) clk = ~clk;

    ibuf_latch #(.LINE_W(LINE_W)) ibuf_latch_inst (
        .clk (clk), .rst_n_i (rst_n),
        .is_init_i (is_init), .is_resteer_i (is_resteer), .is_br_fix_i (is_br_fix),
        .line_even_i (line_even), .line_odd_i (line_odd),
        .fip_e_lsb_i (fip_e_lsb), .fip_o_lsb_i (fip_o_lsb),
        .miss_even_i (miss_even), .miss_odd_i (miss_odd),
        .stall_even_i (stall_even), .stall_odd_i (stall_odd),
        .new_bip_i (new_bip), .old_bip_i (old_bip),
        .slot_data_o (slot_data), .slot_valid_o (slot_valid),
        .even_loaded_o (even_loaded), .odd_loaded_o (odd_loaded)
    );

    ibuf_checker #(.LINE_W(LINE_W), .NAME_LEN(NAME_LEN)) checker_inst (
        .clk (clk), .check_en_i (check_en), .test_name_i (test_name),
        .exp_valid_i (exp_valid), .exp_even_loaded_i (exp_even_loaded),
        .exp_odd_loaded_i (exp_odd_loaded),
        .exp_tag_i ({exp_tag3, exp_tag2, exp_tag1, exp_tag0}),
        .slot_data_i (slot_data), .slot_valid_i (slot_valid),
        .even_loaded_i (even_loaded), .odd_loaded_i (odd_loaded),
        .err_count_o (check_errs), .check_count_o (checks)
    );

    task automatic init_inputs();
        rst_n = 1'b0;
        {is_init, is_resteer, is_br_fix} = 3'b000;
        {tag_even, tag_odd} = 16'h0;
        fip_e_lsb = 2'd0;
        fip_o_lsb = 2'd1;   // odd bank always points at an odd slot
        {miss_even, miss_odd, stall_even, stall_odd} = 4'b0000;
        {new_bip, old_bip} = '0;
        check_en = 1'b0;
        test_name = '0;
        {exp_valid, exp_even_loaded, exp_odd_loaded} = '0;
        {exp_tag0, exp_tag1, exp_tag2, exp_tag3} = '0;
    endtask

    // one trace line drives this cycle's inputs and sets the expected outputs
    task automatic read_vector(output bit ok);
        int n;
        int skipped;
        ok = 1'b0;
        skipped = 0;
        n = $fscanf(fd, "%s", test_name);
        while (n == 1 && test_name == COMMENT_TOK && skipped < SKIP_LIMIT) begin
            skipped++;
            n = $fgets(skip_buf, fd);
            n = $fscanf(fd, "%s", test_name);
        end
        if (n == 1 && test_name != COMMENT_TOK) begin
            n = $fscanf(fd, "%d %d %d %h %h %d %d %d %d %d %d %h %h %b %d %d %h %h %h %h",
                        is_init, is_resteer, is_br_fix, tag_even, tag_odd,
                        fip_e_lsb, fip_o_lsb, miss_even, miss_odd, stall_even, stall_odd,
                        new_bip, old_bip, exp_valid, exp_even_loaded, exp_odd_loaded,
                        exp_tag0, exp_tag1, exp_tag2, exp_tag3);
            if (n == 20) begin
                ok = 1'b1;
            end else begin
                $display("ERROR: trace line of test %0s has missing or bad fields", test_name);
                other_errs++;
            end
        end
    endtask

    initial begin
        init_inputs();
        other_errs = 0;
        fd = $fopen("dv/ibuf_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the trace file dv/ibuf_trace.txt");
            other_errs++;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        wait_cycles = 0;
        while (slot_valid !== '0 && wait_cycles < RST_LIMIT) begin
            @(posedge clk);
            #(DRIVE_DLY);
            wait_cycles++;
        end
        if (slot_valid !== '0) begin
            $display("ERROR: valid bits were still set after %0d reset cycles", RST_LIMIT);
            other_errs++;
        end
        rst_n = 1'b1;
        cycles = 0;
        done = (fd == 0);
        while (!done) begin
            read_vector(got);
            if (!got) begin
                done = 1'b1;
            end else begin
                check_en = 1'b1;
                @(posedge clk);
                #(DRIVE_DLY);
                cycles++;
                if (cycles >= CYCLE_LIMIT) begin
                    $display("ERROR: trace still running after %0d cycles", CYCLE_LIMIT);
                    other_errs++;
                    done = 1'b1;
                end
            end
        end
        check_en = 1'b0;
        if (fd != 0) $fclose(fd);
        if (checks == 0) begin
            $display("ERROR: no trace cycle was checked");
            other_errs++;
        end
        $display("errors: %0d check, %0d other, over %0d checked cycles",
                 check_errs, other_errs, checks);
        if (check_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/ibuf_checker.sv */
module ibuf_checker #(
    parameter int LINE_W   = ibuf_geom_pkg::DEF_LINE_W,
    parameter int NAME_LEN = 24
) (
    input  logic                                           clk,
    input  logic                                           check_en_i,
    input  logic [8*NAME_LEN-1:0]                          test_name_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             exp_valid_i,
    input  logic                                           exp_even_loaded_i,
    input  logic                                           exp_odd_loaded_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0][7:0]        exp_tag_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0][LINE_W-1:0] slot_data_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             slot_valid_i,
    input  logic                                           even_loaded_i,
    input  logic                                           odd_loaded_i,
    output int                                             err_count_o,
    output int                                             check_count_o
);
    import ibuf_geom_pkg::*;

    localparam int SAMPLE_DLY = 6;   // late in the cycle, next edge comes at 8

    int err_count   = 0;
    int check_count = 0;

    assign err_count_o   = err_count;
    assign check_count_o = check_count;

    // the trace names one byte per slot, repeated across the whole line
    function automatic logic [LINE_W-1:0] tag_line(input logic [7:0] tag);
        return {(LINE_W/8){tag}};
    endfunction

    task automatic compare(input string what, input logic [LINE_W-1:0] exp_val,
                           input logic [LINE_W-1:0] act_val);
        if (exp_val !== act_val) begin
            err_count++;
            $display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
                     test_name_i, what, exp_val, act_val);
        end
    endtask

    always @(posedge clk) begin
        #(SAMPLE_DLY);
        if (check_en_i) begin
            check_count++;
            compare("slot_valid", LINE_W'(exp_valid_i), LINE_W'(slot_valid_i));
            compare("even_loaded", LINE_W'(exp_even_loaded_i), LINE_W'(even_loaded_i));
            compare("odd_loaded", LINE_W'(exp_odd_loaded_i), LINE_W'(odd_loaded_i));
            for (int i = 0; i < NUM_SLOTS; i++) begin
                compare($sformatf("slot_data[%0d]", i), tag_line(exp_tag_i[i]),
                        slot_data_i[i]);
            end
        end
    end

endmodule

/* logic/ibuf_latch.sv */
module ibuf_latch #(
    parameter int LINE_W = ibuf_geom_pkg::DEF_LINE_W
) (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           is_init_i,
    input  logic                                           is_resteer_i,
    input  logic                                           is_br_fix_i,
    input  logic [LINE_W-1:0]                              line_even_i,
    input  logic [LINE_W-1:0]                              line_odd_i,
    input  ibuf_geom_pkg::slot_idx_t                       fip_e_lsb_i,
    input  ibuf_geom_pkg::slot_idx_t                       fip_o_lsb_i,
    input  logic                                           miss_even_i,
    input  logic                                           miss_odd_i,
    input  logic                                           stall_even_i,
    input  logic                                           stall_odd_i,
    input  logic [ibuf_geom_pkg::BIP_W-1:0]                 new_bip_i,
    input  logic [ibuf_geom_pkg::BIP_W-1:0]                 old_bip_i,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0][LINE_W-1:0] slot_data_o,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             slot_valid_o,
    output logic                                           even_loaded_o,
    output logic                                           odd_loaded_o
);
    import ibuf_geom_pkg::*;
    import ibuf_mode_pkg::*;

    logic                 cf;
    logic                 miss_any;
    load_mode_t           eff_mode;
    logic [NUM_SLOTS-1:0] ld_strobe;
    logic [NUM_SLOTS-1:0] inval;
    logic [NUM_SLOTS-1:0] slot_valid;

    assign cf       = is_init_i | is_resteer_i | is_br_fix_i;   // any redirect flushes
    assign miss_any = miss_even_i | miss_odd_i;

    ibuf_load_state load_state_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cf_i         (cf),
        .miss_any_i   (miss_any),
        .slot_valid_i (slot_valid),
        .eff_mode_o   (eff_mode)
    );

    ibuf_invalidate invalidate_inst (
        .clk       (clk),
        .new_bip_i (new_bip_i),
        .old_bip_i (old_bip_i),
        .inval_o   (inval)
    );

    ibuf_load_select load_select_inst (
        .clk          (clk),
        .eff_mode_i   (eff_mode),
        .fip_e_lsb_i  (fip_e_lsb_i),
        .fip_o_lsb_i  (fip_o_lsb_i),
        .miss_even_i  (miss_even_i),
        .miss_odd_i   (miss_odd_i),
        .stall_even_i (stall_even_i),
        .stall_odd_i  (stall_odd_i),
        .ld_strobe_o  (ld_strobe)
    );

    ibuf_line_store #(
        .LINE_W (LINE_W)
    ) line_store_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cf_i         (cf),
        .ld_strobe_i  (ld_strobe),
        .inval_i      (inval),
        .line_even_i  (line_even_i),
        .line_odd_i   (line_odd_i),
        .slot_data_o  (slot_data_o),
        .slot_valid_o (slot_valid)
    );

    assign slot_valid_o  = slot_valid;
    assign even_loaded_o = ld_strobe[0] | ld_strobe[2];   // slots 00 and 10
    assign odd_loaded_o  = ld_strobe[1] | ld_strobe[3];

endmodule

/* logic/ibuf_line_store.sv */
module ibuf_line_store #(
    parameter int LINE_W = ibuf_geom_pkg::DEF_LINE_W
) (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           cf_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             ld_strobe_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             inval_i,
    input  logic [LINE_W-1:0]                              line_even_i,
    input  logic [LINE_W-1:0]                              line_odd_i,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0][LINE_W-1:0] slot_data_o,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0]             slot_valid_o
);
    import ibuf_geom_pkg::*;

    logic [NUM_SLOTS-1:0][LINE_W-1:0] bank_line;   // line each slot would take

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            bank_line[i] = (i % 2 == 0) ? line_even_i : line_odd_i;
        end
    end

    // data only moves on a load
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_data_o <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ld_strobe_i[i]) begin
                    slot_data_o[i] <= bank_line[i];
                end
            end
        end
    end

    // load wins over flush, flush over invalidate
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_valid_o <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ld_strobe_i[i]) begin
                    slot_valid_o[i] <= 1'b1;
                end else if (cf_i) begin
                    slot_valid_o[i] <= 1'b0;
                end else if (inval_i[i]) begin
                    slot_valid_o[i] <= 1'b0;   // line fully consumed
                end
            end
        end
    end

endmodule

/* logic/ibuf_load_select.sv */
module ibuf_load_select (
    input  logic                               clk,
    input  ibuf_mode_pkg::load_mode_t          eff_mode_i,
    input  ibuf_geom_pkg::slot_idx_t           fip_e_lsb_i,
    input  ibuf_geom_pkg::slot_idx_t           fip_o_lsb_i,
    input  logic                               miss_even_i,
    input  logic                               miss_odd_i,
    input  logic                               stall_even_i,
    input  logic                               stall_odd_i,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0] ld_strobe_o
);
    import ibuf_geom_pkg::*;
    import ibuf_mode_pkg::*;

    logic want_even;
    logic want_odd;
    logic ld_even;
    logic ld_odd;

    assign want_even = eff_mode_i inside {LD_EVEN, LD_BOTH};
    assign want_odd  = eff_mode_i inside {LD_ODD, LD_BOTH};

    // bank must have the line and must not be held off
    assign ld_even = want_even && !miss_even_i && !stall_even_i;
    assign ld_odd  = want_odd && !miss_odd_i && !stall_odd_i;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ld_strobe_o[i] = (ld_even && (fip_e_lsb_i == slot_idx_t'(i)))
                          || (ld_odd && (fip_o_lsb_i == slot_idx_t'(i)));
        end
    end

    // a bank line may only land in a slot of its own parity
    a_fip_e_even: assert property (@(posedge clk) ld_even |-> !fip_e_lsb_i[0])
        else $error("even bank pointed at an odd slot");

    a_fip_o_odd: assert property (@(posedge clk) ld_odd |-> fip_o_lsb_i[0])
        else $error("odd bank pointed at an even slot");

endmodule

/* logic/ibuf_invalidate.sv */
module ibuf_invalidate (
    input  logic                               clk,
    input  logic [ibuf_geom_pkg::BIP_W-1:0]     new_bip_i,
    input  logic [ibuf_geom_pkg::BIP_W-1:0]     old_bip_i,
    output logic [ibuf_geom_pkg::NUM_SLOTS-1:0] inval_o
);
    import ibuf_geom_pkg::*;

    logic      wrap;
    slot_idx_t old_slot;

    // offset going backwards means the decoder walked off the end of the old line
    assign wrap     = new_bip_i[BIP_OFS_W-1:0] < old_bip_i[BIP_OFS_W-1:0];
    assign old_slot = old_bip_i[BIP_W-1:BIP_OFS_W];

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            inval_o[i] = wrap && (old_slot == slot_idx_t'(i));
        end
    end

    // at most one line can be consumed per cycle
    a_inval_onehot0: assert property (@(posedge clk) $onehot0(inval_o))
        else $error("more than one slot invalidated in a cycle");

endmodule

/* logic/ibuf_load_state.sv */
module ibuf_load_state (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               cf_i,
    input  logic                               miss_any_i,
    input  logic [ibuf_geom_pkg::NUM_SLOTS-1:0] slot_valid_i,
    output ibuf_mode_pkg::load_mode_t          eff_mode_o
);
    import ibuf_geom_pkg::*;
    import ibuf_mode_pkg::*;

    load_mode_t           mode_q;
    load_mode_t           next_mode;
    logic [NUM_SLOTS-1:0] pair_free;   // bit i set when slots i and i+1 are both empty
    logic                 even_free;
    logic                 odd_free;

    always_comb begin
        pair_free = '0;
        even_free = 1'b0;
        odd_free  = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            pair_free[i] = !slot_valid_i[i] && !slot_valid_i[(i + 1) % NUM_SLOTS];  // wraps 11-00
            if (i % 2 == 0) begin
                even_free = even_free | !slot_valid_i[i];
            end else begin
                odd_free = odd_free | !slot_valid_i[i];
            end
        end
    end

    always_comb begin
        if (cf_i || (|pair_free)) begin
            next_mode = LD_BOTH;
        end else if (even_free) begin
            next_mode = LD_EVEN;
        end else if (odd_free) begin
            next_mode = LD_ODD;
        end else begin
            next_mode = LD_NONE;
        end
    end

    // a miss on either bank freezes the mode
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mode_q <= LD_MODE_RST;
        end else if (!miss_any_i) begin
            mode_q <= next_mode;
        end
    end

    assign eff_mode_o = cf_i ? LD_BOTH : mode_q;

    a_cf_forces_both: assert property (@(posedge clk) disable iff (!rst_n_i)
        cf_i |-> eff_mode_o == LD_BOTH)
        else $error("control-flow event without both-bank load");

endmodule

/* logic/ibuf_mode_pkg.sv */
package ibuf_mode_pkg;

    // bit 1 asks for an even line, bit 0 for an odd line
    typedef enum logic [1:0] {
        LD_NONE = 2'd0,
        LD_ODD  = 2'd1,
        LD_EVEN = 2'd2,
        LD_BOTH = 2'd3
    } load_mode_t;

    localparam load_mode_t LD_MODE_RST = LD_BOTH;   // empty buffer wants both banks

endpackage

/* logic/ibuf_geom_pkg.sv */
package ibuf_geom_pkg;

    // four line slots; even slots fill from the even bank, odd ones from the odd bank
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

    // byte pointer is {slot index, byte offset}
    localparam int BIP_OFS_W = 4;                       // 16 bytes per line
    localparam int BIP_W     = SLOT_IDX_W + BIP_OFS_W;

    localparam int DEF_LINE_W = 128;

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

endpackage
